// File: source/dp_config_pkg.sv
package dp_config_pkg;

    // lane and stream word geometry
    localparam int DWIDTH     = 16;
    localparam int SIMD_LANES = 4;
    localparam int PHIT_SIZE  = DWIDTH * SIMD_LANES;

    // per-stage register file
    localparam int RF_DEPTH  = 16;
    localparam int RF_ADDR_W = $clog2(RF_DEPTH);

    // stage latencies in clock cycles
    localparam int LAT_ALU   = 2;
    localparam int LAT_UNARY = 1;

    // A0, A1 and C are binary, B is the single unary stage
    localparam int NUM_BIN_STAGES = 3;

    // stream_in to stream_out, counted in sampling edges
    localparam int PIPE_LATENCY = NUM_BIN_STAGES * LAT_ALU + LAT_UNARY;

endpackage

// File: source/dp_isa_pkg.sv
package dp_isa_pkg;

    // binary lane operations, all on signed 16-bit lanes
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        MIN = 3'd2,
        MAX = 3'd3,
        // low half of the product
        MUL = 3'd4,
        AND = 3'd5,
        OR  = 3'd6,
        XOR = 3'd7
    } alu_op_e;

    // unary lane operations
    typedef enum logic [1:0] {
        PASS = 2'd0,
        NEG  = 2'd1,
        // abs of 0x8000 stays 0x8000
        ABS  = 2'd2,
        // arithmetic shift right by one
        SHR1 = 2'd3
    } unary_op_e;

    // operand sources of a binary stage
    typedef enum logic [1:0] {
        SRC_STREAM = 2'd0,
        SRC_ITER   = 2'd1,
        SRC_IMM    = 2'd2,
        SRC_RF     = 2'd3
    } src_sel_e;

endpackage

// File: source/lane_alu.sv
`timescale 1ns/100ps

module lane_alu (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [dp_config_pkg::DWIDTH-1:0] i_a,
    input  logic [dp_config_pkg::DWIDTH-1:0] i_b,
    input  dp_isa_pkg::alu_op_e             i_op,
    output logic [dp_config_pkg::DWIDTH-1:0] o_y
);
    import dp_config_pkg::*;
    import dp_isa_pkg::*;

    logic [DWIDTH-1:0] a_q;
    logic [DWIDTH-1:0] b_q;
    alu_op_e           op_q;
    logic [DWIDTH-1:0] res;
    logic [DWIDTH-1:0] y_q;

    // first register: operands and opcode
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            a_q  <= '0;
            b_q  <= '0;
            op_q <= ADD;
        end else begin
            a_q  <= i_a;
            b_q  <= i_b;
            op_q <= i_op;
        end
    end

    // the multiplier gets a full cycle between the two registers
    always_comb begin
        case (op_q)
            ADD:     res = a_q + b_q;
            SUB:     res = a_q - b_q;
            MIN:     res = ($signed(a_q) < $signed(b_q)) ? a_q : b_q;
            MAX:     res = ($signed(a_q) > $signed(b_q)) ? a_q : b_q;
            MUL:     res = a_q * b_q;
            AND:     res = a_q & b_q;
            OR:      res = a_q | b_q;
            XOR:     res = a_q ^ b_q;
            default: res = '0;
        endcase
    end

    // second register: result
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            y_q <= '0;
        end else begin
            y_q <= res;
        end
    end

    assign o_y = y_q;

endmodule

// File: source/lane_unary.sv
`timescale 1ns/100ps

module lane_unary (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [dp_config_pkg::DWIDTH-1:0] i_a,
    input  dp_isa_pkg::unary_op_e           i_op,
    output logic [dp_config_pkg::DWIDTH-1:0] o_y
);
    import dp_config_pkg::*;
    import dp_isa_pkg::*;

    logic [DWIDTH-1:0] res;
    logic [DWIDTH-1:0] y_q;

    always_comb begin
        case (i_op)
            PASS:    res = i_a;
            // two's complement, wraps for the most negative value
            NEG:     res = -i_a;
            ABS:     res = i_a[DWIDTH-1] ? -i_a : i_a;
            SHR1:    res = $signed(i_a) >>> 1;
            default: res = i_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            y_q <= '0;
        end else begin
            y_q <= res;
        end
    end

    assign o_y = y_q;

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                               clk,
    input  logic                               i_wen,
    input  logic [dp_config_pkg::RF_ADDR_W-1:0] i_wr_addr,
    input  logic [dp_config_pkg::PHIT_SIZE-1:0] i_wr_data,
    input  logic [dp_config_pkg::RF_ADDR_W-1:0] i_rd_addr,
    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_rd_data
);
    import dp_config_pkg::*;

    // one full phit per entry
    logic [PHIT_SIZE-1:0] mem [RF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_wen) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read is combinational so the operand is ready in the sampling cycle
    assign o_rd_data = mem[i_rd_addr];

endmodule

// File: source/binary_stage.sv
`timescale 1ns/100ps

module binary_stage (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [dp_config_pkg::PHIT_SIZE-1:0] i_stream,
    input  logic [dp_config_pkg::DWIDTH-1:0]    i_iter,
    input  logic [dp_config_pkg::DWIDTH-1:0]    i_imm,
    input  dp_isa_pkg::src_sel_e               i_src_a,
    input  dp_isa_pkg::src_sel_e               i_src_b,
    input  dp_isa_pkg::alu_op_e                i_op,
    input  logic                               i_rf_wen,
    input  logic                               i_rf_iter_addr,
    input  logic [dp_config_pkg::RF_ADDR_W-1:0] i_rf_rd_addr,
    input  logic [dp_config_pkg::RF_ADDR_W-1:0] i_rf_wr_addr,
    input  logic                               i_load_en,
    input  logic [dp_config_pkg::PHIT_SIZE-1:0] i_load_data,
    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_stream
);
    import dp_config_pkg::*;
    import dp_isa_pkg::*;

    logic [PHIT_SIZE-1:0] iter_phit;
    logic [PHIT_SIZE-1:0] imm_phit;
    logic [PHIT_SIZE-1:0] rf_phit;
    logic [PHIT_SIZE-1:0] opnd_a;
    logic [PHIT_SIZE-1:0] opnd_b;
    logic [PHIT_SIZE-1:0] stage_out;
    logic [RF_ADDR_W-1:0] rf_rd_addr;
    logic [PHIT_SIZE-1:0] rf_wr_data;

    // four-way operand source mux, one phit wide
    function automatic logic [PHIT_SIZE-1:0] pick_src(
        input src_sel_e             sel,
        input logic [PHIT_SIZE-1:0] stream,
        input logic [PHIT_SIZE-1:0] iter,
        input logic [PHIT_SIZE-1:0] imm,
        input logic [PHIT_SIZE-1:0] rf
    );
        logic [PHIT_SIZE-1:0] val;
        case (sel)
            SRC_STREAM: val = stream;
            SRC_ITER:   val = iter;
            SRC_IMM:    val = imm;
            SRC_RF:     val = rf;
            default:    val = stream;
        endcase
        return val;
    endfunction

    // broadcast values are the same in every lane
    assign iter_phit = {SIMD_LANES{i_iter}};
    assign imm_phit  = {SIMD_LANES{i_imm}};

    assign opnd_a = pick_src(i_src_a, i_stream, iter_phit, imm_phit, rf_phit);
    assign opnd_b = pick_src(i_src_b, i_stream, iter_phit, imm_phit, rf_phit);

    for (genvar l = 0; l < SIMD_LANES; l++) begin : g_lane
        lane_alu u_alu (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_a     (opnd_a[l*DWIDTH +: DWIDTH]),
            .i_b     (opnd_b[l*DWIDTH +: DWIDTH]),
            .i_op    (i_op),
            .o_y     (stage_out[l*DWIDTH +: DWIDTH])
        );
    end

    // iteration-indexed read lets i_iter walk the table
    assign rf_rd_addr = i_rf_iter_addr ? i_iter[RF_ADDR_W-1:0] : i_rf_rd_addr;

    // host load wins over capture of the stage result
    assign rf_wr_data = i_load_en ? i_load_data : stage_out;

    reg_file u_rf (
        .clk       (clk),
        .i_wen     (i_rf_wen),
        .i_wr_addr (i_rf_wr_addr),
        .i_wr_data (rf_wr_data),
        .i_rd_addr (rf_rd_addr),
        .o_rd_data (rf_phit)
    );

    assign o_stream = stage_out;

endmodule

// File: source/data_path.sv
`timescale 1ns/100ps

module data_path (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [dp_config_pkg::PHIT_SIZE-1:0] i_stream_in,
    input  logic [dp_config_pkg::DWIDTH-1:0]    i_iter,

    // per binary stage, index 0 is A0, 1 is A1, 2 is C
    input  logic [dp_config_pkg::NUM_BIN_STAGES-1:0][dp_config_pkg::DWIDTH-1:0] i_imm,
    input  dp_isa_pkg::src_sel_e [dp_config_pkg::NUM_BIN_STAGES-1:0]          i_src_a,
    input  dp_isa_pkg::src_sel_e [dp_config_pkg::NUM_BIN_STAGES-1:0]          i_src_b,
    input  dp_isa_pkg::alu_op_e  [dp_config_pkg::NUM_BIN_STAGES-1:0]          i_alu_op,
    input  dp_isa_pkg::unary_op_e                                             i_unary_op,
    input  logic [dp_config_pkg::NUM_BIN_STAGES-1:0]                          i_rf_wen,
    input  logic [dp_config_pkg::NUM_BIN_STAGES-1:0]                          i_rf_iter_addr,
    input  logic [dp_config_pkg::NUM_BIN_STAGES-1:0][dp_config_pkg::RF_ADDR_W-1:0]
                                                                              i_rf_rd_addr,
    input  logic [dp_config_pkg::NUM_BIN_STAGES-1:0][dp_config_pkg::RF_ADDR_W-1:0]
                                                                              i_rf_wr_addr,

    // host load path, shared by all register files
    input  logic                               i_load_en,
    input  logic [dp_config_pkg::PHIT_SIZE-1:0] i_load_data,

    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_stream_out,
    // debug taps after A0, A1 and B
    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_tap_a0,
    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_tap_a1,
    output logic [dp_config_pkg::PHIT_SIZE-1:0] o_tap_b
);
    import dp_config_pkg::*;

    logic [PHIT_SIZE-1:0] bin_in  [NUM_BIN_STAGES];
    logic [PHIT_SIZE-1:0] bin_out [NUM_BIN_STAGES];
    logic [PHIT_SIZE-1:0] unary_out;

    // chain order is A0, A1, B, C so C takes its stream from B
    assign bin_in[0] = i_stream_in;
    assign bin_in[1] = bin_out[0];
    assign bin_in[2] = unary_out;

    for (genvar k = 0; k < NUM_BIN_STAGES; k++) begin : g_bin
        binary_stage u_stage (
            .clk            (clk),
            .i_rst_n        (i_rst_n),
            .i_stream       (bin_in[k]),
            .i_iter         (i_iter),
            .i_imm          (i_imm[k]),
            .i_src_a        (i_src_a[k]),
            .i_src_b        (i_src_b[k]),
            .i_op           (i_alu_op[k]),
            .i_rf_wen       (i_rf_wen[k]),
            .i_rf_iter_addr (i_rf_iter_addr[k]),
            .i_rf_rd_addr   (i_rf_rd_addr[k]),
            .i_rf_wr_addr   (i_rf_wr_addr[k]),
            .i_load_en      (i_load_en),
            .i_load_data    (i_load_data),
            .o_stream       (bin_out[k])
        );
    end

    // stage B, one unary unit per lane
    for (genvar l = 0; l < SIMD_LANES; l++) begin : g_unary
        lane_unary u_unary (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_a     (bin_out[1][l*DWIDTH +: DWIDTH]),
            .i_op    (i_unary_op),
            .o_y     (unary_out[l*DWIDTH +: DWIDTH])
        );
    end

    assign o_tap_a0     = bin_out[0];
    assign o_tap_a1     = bin_out[1];
    assign o_tap_b      = unary_out;
    assign o_stream_out = bin_out[2];

endmodule

// File: verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// sign extend one lane to a 32-bit int
function automatic int sext(input logic [DWIDTH-1:0] v);
    return {{(32 - DWIDTH){v[DWIDTH-1]}}, v};
endfunction

// same value in every lane
function automatic logic [PHIT_SIZE-1:0] bcast(input logic [DWIDTH-1:0] v);
    logic [PHIT_SIZE-1:0] p;
    p = '0;
    for (int l = 0; l < SIMD_LANES; l++) begin
        p[l*DWIDTH +: DWIDTH] = v;
    end
    return p;
endfunction

// binary lane rule, computed wide and wrapped to 16 bits
function automatic logic [DWIDTH-1:0] alu_lane(input alu_op_e op,
                                               input logic [DWIDTH-1:0] a,
                                               input logic [DWIDTH-1:0] b);
    int sa;
    int sb;
    int r;
    sa = sext(a);
    sb = sext(b);
    case (op)
        ADD:     r = sa + sb;
        SUB:     r = sa - sb;
        MIN:     r = (sa < sb) ? sa : sb;
        MAX:     r = (sa > sb) ? sa : sb;
        MUL:     r = sa * sb;
        AND:     r = sa & sb;
        OR:      r = sa | sb;
        XOR:     r = sa ^ sb;
        default: r = 0;
    endcase
    return r[DWIDTH-1:0];
endfunction

// unary lane rule, abs of the most negative value wraps back
function automatic logic [DWIDTH-1:0] unary_lane(input unary_op_e op,
                                                 input logic [DWIDTH-1:0] a);
    int sa;
    int r;
    sa = sext(a);
    case (op)
        NEG:     r = 0 - sa;
        ABS:     r = (sa < 0) ? 0 - sa : sa;
        SHR1:    r = sa >>> 1;
        default: r = sa;
    endcase
    return r[DWIDTH-1:0];
endfunction

function automatic logic [PHIT_SIZE-1:0] alu_phit(input alu_op_e op,
                                                  input logic [PHIT_SIZE-1:0] a,
                                                  input logic [PHIT_SIZE-1:0] b);
    logic [PHIT_SIZE-1:0] y;
    y = '0;
    for (int l = 0; l < SIMD_LANES; l++) begin
        y[l*DWIDTH +: DWIDTH] = alu_lane(op, a[l*DWIDTH +: DWIDTH], b[l*DWIDTH +: DWIDTH]);
    end
    return y;
endfunction

function automatic logic [PHIT_SIZE-1:0] unary_phit(input unary_op_e op,
                                                    input logic [PHIT_SIZE-1:0] a);
    logic [PHIT_SIZE-1:0] y;
    y = '0;
    for (int l = 0; l < SIMD_LANES; l++) begin
        y[l*DWIDTH +: DWIDTH] = unary_lane(op, a[l*DWIDTH +: DWIDTH]);
    end
    return y;
endfunction

`endif

// File: verification/tb_data_path.sv
`timescale 1ns/100ps

module tb_data_path;
    import dp_config_pkg::*;
    import dp_isa_pkg::*;

    `include "tb_ref_model.svh"

    logic                                          clk;
    logic                                          i_rst_n;
    logic [PHIT_SIZE-1:0]                          i_stream_in;
    logic [DWIDTH-1:0]                             i_iter;
    logic [NUM_BIN_STAGES-1:0][DWIDTH-1:0]         i_imm;
    src_sel_e [NUM_BIN_STAGES-1:0]                 i_src_a;
    src_sel_e [NUM_BIN_STAGES-1:0]                 i_src_b;
    alu_op_e [NUM_BIN_STAGES-1:0]                  i_alu_op;
    unary_op_e                                     i_unary_op;
    logic [NUM_BIN_STAGES-1:0]                     i_rf_wen;
    logic [NUM_BIN_STAGES-1:0]                     i_rf_iter_addr;
    logic [NUM_BIN_STAGES-1:0][RF_ADDR_W-1:0]      i_rf_rd_addr;
    logic [NUM_BIN_STAGES-1:0][RF_ADDR_W-1:0]      i_rf_wr_addr;
    logic                                          i_load_en;
    logic [PHIT_SIZE-1:0]                          i_load_data;
    logic [PHIT_SIZE-1:0]                          o_stream_out;
    logic [PHIT_SIZE-1:0]                          o_tap_a0;
    logic [PHIT_SIZE-1:0]                          o_tap_a1;
    logic [PHIT_SIZE-1:0]                          o_tap_b;

    int seed;
    int error_count;
    int check_count;
    int test_count;
    int test_errors;
    int test_checks;

    // host copy of the written register file entries
    logic [PHIT_SIZE-1:0] rf_shadow [NUM_BIN_STAGES][RF_DEPTH];
    logic [PHIT_SIZE-1:0] stim_q [$];

    data_path UUT (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_stream_in    (i_stream_in),
        .i_iter         (i_iter),
        .i_imm          (i_imm),
        .i_src_a        (i_src_a),
        .i_src_b        (i_src_b),
        .i_alu_op       (i_alu_op),
        .i_unary_op     (i_unary_op),
        .i_rf_wen       (i_rf_wen),
        .i_rf_iter_addr (i_rf_iter_addr),
        .i_rf_rd_addr   (i_rf_rd_addr),
        .i_rf_wr_addr   (i_rf_wr_addr),
        .i_load_en      (i_load_en),
        .i_load_data    (i_load_data),
        .o_stream_out   (o_stream_out),
        .o_tap_a0       (o_tap_a0),
        .o_tap_a1       (o_tap_a1),
        .o_tap_b        (o_tap_b)
    );

    always #10 clk = ~clk;

    function automatic logic [DWIDTH-1:0] rand_lane();
        logic [31:0] r;
        r = $random(seed);
        return r[DWIDTH-1:0];
    endfunction

    function automatic logic [PHIT_SIZE-1:0] rand_phit();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // operand of binary stage k as the source rules define it
    function automatic logic [PHIT_SIZE-1:0] operand(input int k, input src_sel_e sel,
                                                     input logic [PHIT_SIZE-1:0] stream);
        logic [RF_ADDR_W-1:0] addr;
        addr = i_rf_iter_addr[k] ? i_iter[RF_ADDR_W-1:0] : i_rf_rd_addr[k];
        if (sel == SRC_STREAM) begin
            return stream;
        end else if (sel == SRC_ITER) begin
            return bcast(i_iter);
        end else if (sel == SRC_IMM) begin
            return bcast(i_imm[k]);
        end
        return rf_shadow[k][addr];
    endfunction

    function automatic logic [PHIT_SIZE-1:0] stage_model(input int k,
                                                         input logic [PHIT_SIZE-1:0] x);
        return alu_phit(i_alu_op[k], operand(k, i_src_a[k], x), operand(k, i_src_b[k], x));
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [PHIT_SIZE-1:0] exp,
                             input logic [PHIT_SIZE-1:0] act);
        check_count++;
        test_checks++;
        if (act !== exp) begin
            $display("Error: %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_count++;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %0d checks, %0d errors", test_count, name, test_checks,
                 test_errors);
    endtask

    // every stage passes its stream through unchanged
    task automatic apply_defaults();
        for (int k = 0; k < NUM_BIN_STAGES; k++) begin
            i_src_a[k]        = SRC_STREAM;
            i_src_b[k]        = SRC_IMM;
            i_alu_op[k]       = ADD;
            i_imm[k]          = '0;
            i_rf_wen[k]       = 1'b0;
            i_rf_iter_addr[k] = 1'b0;
            i_rf_rd_addr[k]   = '0;
            i_rf_wr_addr[k]   = '0;
        end
        i_unary_op  = PASS;
        i_iter      = '0;
        i_load_en   = 1'b0;
        i_load_data = '0;
        i_stream_in = '0;
    endtask

    // drive stim_q back to back and check every tap at its own latency
    task automatic run_stream();
        int n;
        int j;
        logic [PHIT_SIZE-1:0] exp_a0 [$];
        logic [PHIT_SIZE-1:0] exp_a1 [$];
        logic [PHIT_SIZE-1:0] exp_b [$];
        logic [PHIT_SIZE-1:0] exp_c [$];
        n = stim_q.size();
        foreach (stim_q[i]) begin
            exp_a0.push_back(stage_model(0, stim_q[i]));
            exp_a1.push_back(stage_model(1, exp_a0[i]));
            exp_b.push_back(unary_phit(i_unary_op, exp_a1[i]));
            exp_c.push_back(stage_model(2, exp_b[i]));
        end
        for (int c = 0; c < n + PIPE_LATENCY; c++) begin
            step();
            i_stream_in = (c < n) ? stim_q[c] : '0;
            @(negedge clk);
            j = c - LAT_ALU;
            if (j >= 0 && j < n) begin
                check_val("o_tap_a0", exp_a0[j], o_tap_a0);
            end
            j = c - 2 * LAT_ALU;
            if (j >= 0 && j < n) begin
                check_val("o_tap_a1", exp_a1[j], o_tap_a1);
            end
            j = c - 2 * LAT_ALU - LAT_UNARY;
            if (j >= 0 && j < n) begin
                check_val("o_tap_b", exp_b[j], o_tap_b);
            end
            j = c - PIPE_LATENCY;
            if (j >= 0 && j < n) begin
                check_val("o_stream_out", exp_c[j], o_stream_out);
            end
        end
        stim_q.delete();
    endtask

    task automatic test_reset_state();
        start_test();
        i_rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        // fill every stage with nonzero data before resetting again
        i_stream_in = 64'h1234_8001_7FFF_FFFF;
        repeat (PIPE_LATENCY) step();
        i_stream_in = '0;
        i_rst_n     = 1'b0;
        repeat (3) step();
        i_rst_n = 1'b1;
        @(negedge clk);
        check_val("o_stream_out", '0, o_stream_out);
        check_val("o_tap_a0", '0, o_tap_a0);
        check_val("o_tap_a1", '0, o_tap_a1);
        check_val("o_tap_b", '0, o_tap_b);
        finish_test("reset state");
    endtask

    task automatic test_streaming();
        start_test();
        step();
        apply_defaults();
        i_imm[0]    = rand_lane();
        i_src_b[1]  = SRC_ITER;
        i_alu_op[1] = MUL;
        i_iter      = rand_lane();
        i_unary_op  = NEG;
        i_alu_op[2] = MAX;
        i_imm[2]    = rand_lane();
        repeat (20) stim_q.push_back(rand_phit());
        run_stream();
        finish_test("back-to-back streaming");
    endtask

    task automatic test_opcode_sweep();
        logic [DWIDTH-1:0] imm_vals [3];
        start_test();
        step();
        apply_defaults();
        imm_vals[0] = 16'h7FFF;
        imm_vals[1] = 16'h8000;
        imm_vals[2] = rand_lane();
        for (int o = 0; o < (1 << $bits(alu_op_e)); o++) begin
            for (int v = 0; v < 3; v++) begin
                step();
                i_alu_op[2] = alu_op_e'(o[2:0]);
                i_imm[2]    = imm_vals[v];
                stim_q.push_back(64'h7FFF_8000_0000_FFFF);
                stim_q.push_back(64'h8000_7FFF_8000_7FFF);
                repeat (3) stim_q.push_back(rand_phit());
                run_stream();
            end
        end
        finish_test("opcode sweep on stage C");
    endtask

    task automatic test_unary_ops();
        start_test();
        step();
        apply_defaults();
        for (int u = 0; u < (1 << $bits(unary_op_e)); u++) begin
            step();
            i_unary_op = unary_op_e'(u[1:0]);
            stim_q.push_back(64'h8000_7FFF_FFFF_0000);
            stim_q.push_back(64'hFFFE_8001_C000_0001);
            repeat (4) stim_q.push_back(rand_phit());
            run_stream();
        end
        finish_test("unary ops");
    endtask

    task automatic test_rf_host_load();
        logic [DWIDTH-1:0] r;
        start_test();
        step();
        apply_defaults();
        for (int e = 0; e < 6; e++) begin
            rf_shadow[0][e] = rand_phit();
            i_load_en       = 1'b1;
            i_load_data     = rf_shadow[0][e];
            i_rf_wen[0]     = 1'b1;
            i_rf_wr_addr[0] = e[RF_ADDR_W-1:0];
            step();
        end
        i_load_en   = 1'b0;
        i_rf_wen[0] = 1'b0;
        i_src_b[0]  = SRC_RF;
        // explicit read address
        for (int e = 5; e >= 0; e -= 2) begin
            step();
            i_rf_rd_addr[0] = e[RF_ADDR_W-1:0];
            repeat (3) stim_q.push_back(rand_phit());
            run_stream();
        end
        // low bits of i_iter pick the entry and upper bits are ignored
        for (int e = 0; e < 6; e += 2) begin
            step();
            r                 = rand_lane();
            i_rf_iter_addr[0] = 1'b1;
            i_rf_rd_addr[0]   = 4'd5;
            i_iter            = {r[DWIDTH-1:RF_ADDR_W], e[RF_ADDR_W-1:0]};
            repeat (3) stim_q.push_back(rand_phit());
            run_stream();
        end
        finish_test("register file from host");
    endtask

    // push one phit through A0 and write its result into entry addr
    task automatic capture_a0(input int addr, input logic [PHIT_SIZE-1:0] x);
        logic [PHIT_SIZE-1:0] exp;
        exp = stage_model(0, x);
        step();
        i_stream_in = x;
        step();
        i_stream_in = '0;
        step();
        i_rf_wr_addr[0] = addr[RF_ADDR_W-1:0];
        i_rf_wen[0]     = 1'b1;
        @(negedge clk);
        check_val("o_tap_a0", exp, o_tap_a0);
        step();
        i_rf_wen[0]        = 1'b0;
        rf_shadow[0][addr] = exp;
    endtask

    task automatic test_rf_capture();
        start_test();
        step();
        apply_defaults();
        i_imm[0] = rand_lane();
        capture_a0(9, rand_phit());
        // accumulate stream into entry 9
        i_src_b[0]      = SRC_RF;
        i_rf_rd_addr[0] = 4'd9;
        capture_a0(9, rand_phit());
        capture_a0(9, rand_phit());
        repeat (5) stim_q.push_back(rand_phit());
        run_stream();
        finish_test("register file capture");
    endtask

    initial begin
        seed        = 37803;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        clk         = 1'b0;
        i_rst_n     = 1'b0;
        apply_defaults();

        test_reset_state();
        test_streaming();
        test_opcode_sweep();
        test_unary_ops();
        test_rf_host_load();
        test_rf_capture();

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verification
source/dp_config_pkg.sv
source/dp_isa_pkg.sv
source/lane_alu.sv
source/lane_unary.sv
source/reg_file.sv
source/binary_stage.sv
source/data_path.sv
verification/tb_data_path.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_data_path \
		-f compile.f -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
